/* common/ex_pkg.sv */
package ex_pkg;

    typedef logic [31:0] word_t;      // operands, results, addresses
    typedef logic [18:0] vppn_t;      // va[31:13]
    typedef logic [19:0] ppn_t;       // 4 KB physical page
    typedef logic [9:0]  asid_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_DIVU,    // multi-cycle
        ALU_MODU     // multi-cycle
    } alu_op_e;

    // same codes as the sram size field
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef logic [2:0] ex_cause_t;
    localparam int CAUSE_ALE  = 0;    // misaligned
    localparam int CAUSE_TLBR = 1;    // no matching entry
    localparam int CAUSE_PIF  = 2;    // page invalid

    localparam int TLB_ENTRIES = 16;
    typedef logic [3:0] tlb_index_t;

endpackage

/* common/alu_if.sv */
`timescale 1ns/1ns

interface alu_if;
    import ex_pkg::*;

    alu_op_e op;
    word_t   src1;
    word_t   src2;
    logic    start;       // one cycle, on acceptance
    word_t   result;
    logic    complete;    // held until next start

    modport stage (
        output op, src1, src2, start,
        input  result, complete
    );
    modport alu (
        input  op, src1, src2, start,
        output result, complete
    );
endinterface

/* common/tlb_search_if.sv */
`timescale 1ns/1ns

interface tlb_search_if;
    import ex_pkg::*;

    vppn_t      vppn;
    logic       va_bit12;    // picks the even or odd page of the pair
    asid_t      asid;
    logic       found;
    tlb_index_t index;
    ppn_t       ppn;
    logic       v;

    modport requester (
        output vppn, va_bit12, asid,
        input  found, index, ppn, v
    );

    // combinational answer
    modport tlb (
        input  vppn, va_bit12, asid,
        output found, index, ppn, v
    );
endinterface

/* ex_stage/ex_alu.sv */
`timescale 1ns/1ns

module ex_alu (
    input  logic clk,
    input  logic resetn,
    alu_if.alu   alu
);
    import ex_pkg::*;

    alu_op_e     op_q;
    word_t       res_q;         // single-cycle result
    word_t       quo_q;         // dividend shifts out, quotient shifts in
    word_t       rem_q;
    word_t       divisor_q;
    logic [4:0]  step_q;
    logic        busy_q;
    logic        complete_q;
    logic        is_div;
    word_t       simple_res;
    logic [32:0] rem_shift;
    logic [32:0] diff;

    assign is_div = (alu.op == ALU_DIVU) || (alu.op == ALU_MODU);

    always_comb begin
        case (alu.op)
            ALU_ADD:  simple_res = alu.src1 + alu.src2;
            ALU_SUB:  simple_res = alu.src1 - alu.src2;
            ALU_AND:  simple_res = alu.src1 & alu.src2;
            ALU_OR:   simple_res = alu.src1 | alu.src2;
            ALU_XOR:  simple_res = alu.src1 ^ alu.src2;
            ALU_SLL:  simple_res = alu.src1 << alu.src2[4:0];
            ALU_SRL:  simple_res = alu.src1 >> alu.src2[4:0];
            ALU_SRA:  simple_res = $signed(alu.src1) >>> alu.src2[4:0];
            ALU_SLT:  simple_res = {31'b0, $signed(alu.src1) < $signed(alu.src2)};
            ALU_SLTU: simple_res = {31'b0, alu.src1 < alu.src2};
            default:  simple_res = '0;
        endcase
    end

    // one restoring step, a zero divisor ends as all ones / dividend
    assign rem_shift = {rem_q, quo_q[31]};
    assign diff      = rem_shift - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q     <= 1'b0;
            complete_q <= 1'b0;
            step_q     <= '0;
        end else if (alu.start) begin
            busy_q     <= is_div;
            complete_q <= ~is_div;    // single-cycle done next cycle
            step_q     <= '0;
        end else if (busy_q) begin
            step_q <= step_q + 5'd1;
            if (step_q == 5'd31) begin
                busy_q     <= 1'b0;
                complete_q <= 1'b1;    // with the last step
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu.start) begin
            op_q      <= alu.op;
            res_q     <= simple_res;
            quo_q     <= alu.src1;
            rem_q     <= '0;
            divisor_q <= alu.src2;
        end else if (busy_q) begin
            if (!diff[32]) begin
                rem_q <= diff[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= rem_shift[31:0];    // restore
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

    assign alu.result   = (op_q == ALU_DIVU) ? quo_q :
                          (op_q == ALU_MODU) ? rem_q : res_q;
    assign alu.complete = complete_q;

endmodule

/* ex_stage/ex_stage.sv */
`timescale 1ns/1ns

module ex_stage (
    input  logic              clk,
    input  logic              resetn,
    input  logic              flush,
    input  ex_pkg::asid_t     csr_asid,
    input  logic              id_valid,
    input  ex_pkg::alu_op_e   id_alu_op,
    input  ex_pkg::word_t     id_src1,
    input  ex_pkg::word_t     id_src2,
    input  ex_pkg::word_t     id_store_data,
    input  logic              id_load,
    input  logic              id_store,
    input  ex_pkg::mem_size_e id_size,
    input  logic              id_rf_we,
    input  ex_pkg::reg_addr_t id_rf_waddr,
    output logic              ex_allowin,
    input  logic              mem_allowin,
    output logic              ex_to_mem_valid,
    output ex_pkg::word_t     ex_result,
    output logic              ex_rf_we,
    output ex_pkg::reg_addr_t ex_rf_waddr,
    output ex_pkg::ex_cause_t ex_cause,
    output ex_pkg::word_t     ex_paddr,
    output logic              data_sram_req,
    output logic              data_sram_wr,
    output logic [1:0]        data_sram_size,
    output logic [3:0]        data_sram_wstrb,
    output ex_pkg::word_t     data_sram_addr,
    output ex_pkg::word_t     data_sram_wdata,
    input  logic              data_sram_addr_ok,
    alu_if.stage              alu,
    tlb_search_if.requester   tlb_s
);
    import ex_pkg::*;

    logic      ex_valid;
    logic      ready_go;
    logic      load_q;
    logic      store_q;
    mem_size_e size_q;
    word_t     store_data_q;
    logic      rf_we_q;
    reg_addr_t rf_waddr_q;
    word_t     vaddr;
    logic      mem_inst;
    logic [3:0] strb;

    // operands go straight to the alu, it latches them on start
    assign alu.start = id_valid & ex_allowin;
    assign alu.op    = id_alu_op;
    assign alu.src1  = id_src1;
    assign alu.src2  = id_src2;

    assign ready_go        = alu.complete & (~data_sram_req | data_sram_addr_ok);
    assign ex_allowin      = ~ex_valid | (ready_go & mem_allowin);
    assign ex_to_mem_valid = ex_valid & ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;    // drop held instruction
        end else if (ex_allowin) begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid && ex_allowin) begin
            load_q       <= id_load;
            store_q      <= id_store;
            size_q       <= id_size;
            store_data_q <= id_store_data;
            rf_we_q      <= id_rf_we;
            rf_waddr_q   <= id_rf_waddr;
        end
    end

    assign vaddr          = alu.result;    // load/store address from the adder
    assign mem_inst       = load_q | store_q;
    assign tlb_s.vppn     = vaddr[31:13];
    assign tlb_s.va_bit12 = vaddr[12];
    assign tlb_s.asid     = csr_asid;

    assign ex_cause[CAUSE_ALE]  = mem_inst & (((size_q == SIZE_HALF) & vaddr[0]) |
                                              ((size_q == SIZE_WORD) & (vaddr[1:0] != 2'b00)));
    assign ex_cause[CAUSE_TLBR] = mem_inst & ~tlb_s.found;
    assign ex_cause[CAUSE_PIF]  = mem_inst & tlb_s.found & ~tlb_s.v;

    assign ex_paddr = (ex_cause == '0) ? {tlb_s.ppn, vaddr[11:0]} : '0;

    always_comb begin
        case (size_q)
            SIZE_BYTE: begin
                data_sram_wdata = {4{store_data_q[7:0]}};
                strb            = 4'b0001 << vaddr[1:0];
            end
            SIZE_HALF: begin
                data_sram_wdata = {2{store_data_q[15:0]}};
                strb            = vaddr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                data_sram_wdata = store_data_q;
                strb            = 4'b1111;
            end
        endcase
    end

    assign data_sram_req   = ex_valid & mem_inst & (ex_cause == '0) & ~flush & mem_allowin;
    assign data_sram_wr    = store_q;
    assign data_sram_size  = size_q;
    assign data_sram_wstrb = store_q ? strb : 4'b0000;    // loads carry no strobes
    assign data_sram_addr  = ex_paddr;

    assign ex_result   = alu.result;
    assign ex_rf_we    = rf_we_q & ex_valid;
    assign ex_rf_waddr = rf_waddr_q;

endmodule

/* tlb/tlb.sv */
`timescale 1ns/1ns

module tlb #(
    parameter int TLB_ENTRIES = ex_pkg::TLB_ENTRIES
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               tlb_we,
    input  ex_pkg::tlb_index_t tlb_w_index,
    input  ex_pkg::vppn_t      tlb_w_vppn,
    input  ex_pkg::asid_t      tlb_w_asid,
    input  logic               tlb_w_g,
    input  ex_pkg::ppn_t       tlb_w_ppn0,
    input  logic               tlb_w_v0,
    input  ex_pkg::ppn_t       tlb_w_ppn1,
    input  logic               tlb_w_v1,
    tlb_search_if.tlb          tlb_s
);
    import ex_pkg::*;

    logic [TLB_ENTRIES-1:0] e_exists;
    vppn_t                  e_vppn [TLB_ENTRIES];
    asid_t                  e_asid [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] e_g;
    ppn_t                   e_ppn0 [TLB_ENTRIES];
    ppn_t                   e_ppn1 [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] e_v0;
    logic [TLB_ENTRIES-1:0] e_v1;
    logic [TLB_ENTRIES-1:0] match;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            e_exists <= '0;
        end else if (tlb_we) begin
            e_exists[tlb_w_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin    // whole entry at once
            e_vppn[tlb_w_index] <= tlb_w_vppn;
            e_asid[tlb_w_index] <= tlb_w_asid;
            e_g[tlb_w_index]    <= tlb_w_g;
            e_ppn0[tlb_w_index] <= tlb_w_ppn0;
            e_v0[tlb_w_index]   <= tlb_w_v0;
            e_ppn1[tlb_w_index] <= tlb_w_ppn1;
            e_v1[tlb_w_index]   <= tlb_w_v1;
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = e_exists[i] && (e_vppn[i] == tlb_s.vppn) &&
                       (e_g[i] || (e_asid[i] == tlb_s.asid));
        end
    end

    // walk down so the lowest hit wins
    always_comb begin
        tlb_s.found = 1'b0;
        tlb_s.index = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                tlb_s.found = 1'b1;
                tlb_s.index = tlb_index_t'(i);
            end
        end
    end

    assign tlb_s.ppn = tlb_s.va_bit12 ? e_ppn1[tlb_s.index] : e_ppn0[tlb_s.index];
    assign tlb_s.v   = tlb_s.va_bit12 ? e_v1[tlb_s.index] : e_v0[tlb_s.index];

endmodule

/* rtl/ex_top.sv */
`timescale 1ns/1ns

module ex_top #(
    parameter int TLB_ENTRIES = ex_pkg::TLB_ENTRIES
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               flush,
    input  ex_pkg::asid_t      csr_asid,
    input  logic               id_valid,
    input  ex_pkg::alu_op_e    id_alu_op,
    input  ex_pkg::word_t      id_src1,
    input  ex_pkg::word_t      id_src2,
    input  ex_pkg::word_t      id_store_data,
    input  logic               id_load,
    input  logic               id_store,
    input  ex_pkg::mem_size_e  id_size,
    input  logic               id_rf_we,
    input  ex_pkg::reg_addr_t  id_rf_waddr,
    output logic               ex_allowin,
    input  logic               mem_allowin,
    output logic               ex_to_mem_valid,
    output ex_pkg::word_t      ex_result,
    output logic               ex_rf_we,
    output ex_pkg::reg_addr_t  ex_rf_waddr,
    output ex_pkg::ex_cause_t  ex_cause,
    output ex_pkg::word_t      ex_paddr,
    output logic               data_sram_req,
    output logic               data_sram_wr,
    output logic [1:0]         data_sram_size,
    output logic [3:0]         data_sram_wstrb,
    output ex_pkg::word_t      data_sram_addr,
    output ex_pkg::word_t      data_sram_wdata,
    input  logic               data_sram_addr_ok,
    input  logic               tlb_we,
    input  ex_pkg::tlb_index_t tlb_w_index,
    input  ex_pkg::vppn_t      tlb_w_vppn,
    input  ex_pkg::asid_t      tlb_w_asid,
    input  logic               tlb_w_g,
    input  ex_pkg::ppn_t       tlb_w_ppn0,
    input  logic               tlb_w_v0,
    input  ex_pkg::ppn_t       tlb_w_ppn1,
    input  logic               tlb_w_v1
);
    alu_if        alu ();      // stage <-> alu
    tlb_search_if tlb_s ();    // stage <-> tlb lookup

    // ports match by name
    ex_stage u_ex_stage (.*);
    ex_alu   u_ex_alu (.*);
    tlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb (.*);

endmodule

/* verification/ex_checker.sv */
`timescale 1ns/1ns

module ex_checker (
    input logic              clk,
    input logic              resetn,
    input logic              flush,
    input logic              ex_valid,
    input logic              alu_start,
    input logic              alu_complete,
    input logic              data_sram_req,
    input logic [1:0]        data_sram_size,
    input ex_pkg::word_t     data_sram_addr
);
    int failures = 0;    // failed assertions so far

    // a flushed stage is empty at the next edge
    flush_drops: assert property (@(posedge clk) disable iff (!resetn)
        flush |=> !ex_valid && !data_sram_req)
        else begin
            $error("stage still valid after a flush");
            failures++;
        end

    // half and word requests sit on their natural boundary
    req_aligned: assert property (@(posedge clk) disable iff (!resetn)
        data_sram_req |-> (data_sram_size != 2'd1 || !data_sram_addr[0]) &&
                          (data_sram_size != 2'd2 || data_sram_addr[1:0] == 2'b00))
        else begin
            $error("data_sram_req with a misaligned address");
            failures++;
        end

    complete_held: assert property (@(posedge clk) disable iff (!resetn)
        alu_complete && !alu_start |=> alu_complete)
        else begin
            $error("ALU complete dropped without a new start");
            failures++;
        end

    idle_after_reset: assert property (@(posedge clk)
        !resetn |=> !ex_valid && !data_sram_req && !alu_complete)
        else begin
            $error("stage not idle after reset");
            failures++;
        end
endmodule

bind ex_stage ex_checker u_ex_checker (
    .clk            (clk),
    .resetn         (resetn),
    .flush          (flush),
    .ex_valid       (ex_valid),
    .alu_start      (alu.start),
    .alu_complete   (alu.complete),
    .data_sram_req  (data_sram_req),
    .data_sram_size (data_sram_size),
    .data_sram_addr (data_sram_addr)
);

/* verification/tb_ex_top.sv */
`timescale 1ns/1ns

module tb_ex_top;
    import ex_pkg::*;

    localparam int TIMEOUT = 100;    // cycles per wait

    logic       clk;
    logic       resetn;
    logic       flush;
    asid_t      csr_asid;
    logic       id_valid;
    alu_op_e    id_alu_op;
    word_t      id_src1, id_src2, id_store_data;
    logic       id_load, id_store, id_rf_we;
    mem_size_e  id_size;
    reg_addr_t  id_rf_waddr;
    logic       ex_allowin, mem_allowin, ex_to_mem_valid, ex_rf_we;
    word_t      ex_result, ex_paddr;
    reg_addr_t  ex_rf_waddr;
    ex_cause_t  ex_cause;
    logic       data_sram_req, data_sram_wr, data_sram_addr_ok;
    logic [1:0] data_sram_size;
    logic [3:0] data_sram_wstrb;
    word_t      data_sram_addr, data_sram_wdata;
    logic       tlb_we, tlb_w_g, tlb_w_v0, tlb_w_v1;
    tlb_index_t tlb_w_index;
    vppn_t      tlb_w_vppn;
    asid_t      tlb_w_asid;
    ppn_t       tlb_w_ppn0, tlb_w_ppn1;
    integer     seed;

    ex_top #(.TLB_ENTRIES(TLB_ENTRIES)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run();
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check(string what, word_t got, word_t exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic timeout_fail(string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
        fail_run();
    endtask

    function automatic word_t model_alu(alu_op_e op, word_t a, word_t b);
        logic [63:0] ext;
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA: begin
                ext = {{32{a[31]}}, a} >> b[4:0];    // sign fill from the upper half
                return ext[31:0];
            end
            ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            ALU_SLTU: return {31'b0, a < b};
            ALU_DIVU: return (b == 0) ? 32'hffff_ffff : a / b;
            ALU_MODU: return (b == 0) ? a : a % b;
            default:  return '0;
        endcase
    endfunction

    // one strobe per byte lane that the access covers
    function automatic logic [3:0] model_strb(mem_size_e size, logic [1:0] lo);
        logic [3:0] s;
        int         first;
        int         bytes;
        bytes = 1 << int'(size);
        first = int'(lo) & ~(bytes - 1);    // lowest lane of the access
        for (int j = 0; j < 4; j++) begin
            s[j] = (j >= first) && (j < first + bytes);
        end
        return s;
    endfunction

    function automatic word_t model_wdata(mem_size_e size, word_t d);
        case (size)
            SIZE_BYTE: return {d[7:0], d[7:0], d[7:0], d[7:0]};
            SIZE_HALF: return {d[15:0], d[15:0]};
            default:   return d;
        endcase
    endfunction

    task automatic fill_tlb(tlb_index_t idx, vppn_t vppn, asid_t asid, logic g,
                            ppn_t p0, logic v0, ppn_t p1, logic v1);
        @(negedge clk);
        tlb_we      = 1'b1;
        tlb_w_index = idx;
        tlb_w_vppn  = vppn;
        tlb_w_asid  = asid;
        tlb_w_g     = g;
        tlb_w_ppn0  = p0;
        tlb_w_v0    = v0;
        tlb_w_ppn1  = p1;
        tlb_w_v1    = v1;
        @(negedge clk);
        tlb_we = 1'b0;
    endtask

    // returns on the falling edge after the accepting edge
    task automatic issue(alu_op_e op, word_t a, word_t b, logic ld, logic st,
                         mem_size_e size, word_t sdata, reg_addr_t waddr);
        int n;
        @(negedge clk);
        id_valid      = 1'b1;
        id_alu_op     = op;
        id_src1       = a;
        id_src2       = b;
        id_load       = ld;
        id_store      = st;
        id_size       = size;
        id_store_data = sdata;
        id_rf_we      = ~st;
        id_rf_waddr   = waddr;
        n = 0;
        #1;
        while (!ex_allowin) begin
            n++;
            if (n > TIMEOUT) timeout_fail("ex_allowin");
            @(negedge clk);
            #1;
        end
        @(posedge clk);    // accepted here
        @(negedge clk);
        id_valid = 1'b0;
    endtask

    // cycle 1 is the cycle right after acceptance
    task automatic wait_handoff(output int cycles);
        cycles = 1;
        #1;
        while (!(ex_to_mem_valid && mem_allowin)) begin
            if (cycles >= TIMEOUT) timeout_fail("ex_to_mem_valid");
            @(negedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic test_single_cycle(int count);
        alu_op_e   op;
        word_t     a;
        word_t     b;
        reg_addr_t wa;
        int        cyc;
        for (int i = 0; i < count; i++) begin
            op = alu_op_e'(4'($unsigned($random(seed)) % 10));
            a  = $random(seed);
            b  = $random(seed);
            wa = 5'($random(seed));
            issue(op, a, b, 1'b0, 1'b0, SIZE_WORD, '0, wa);
            wait_handoff(cyc);
            check("single-cycle latency", cyc, 1);
            check("ex_result", ex_result, model_alu(op, a, b));
            check("ex_rf_waddr", 32'(ex_rf_waddr), 32'(wa));
            check("ex_rf_we", 32'(ex_rf_we), 1);
        end
    endtask

    task automatic test_division(int count);
        alu_op_e op;
        word_t   a;
        word_t   b;
        int      cyc;
        for (int i = 0; i < count; i++) begin
            op = (i % 2 == 0) ? ALU_DIVU : ALU_MODU;
            a  = $random(seed);
            b  = (i < 2) ? '0 : word_t'($random(seed)) >> (i % 24);    // zero divisor first
            issue(op, a, b, 1'b0, 1'b0, SIZE_WORD, '0, 5'd7);
            wait_handoff(cyc);
            check("division latency", cyc, 33);
            check("division result", ex_result, model_alu(op, a, b));
        end
    endtask

    task automatic run_access(logic ld, word_t va, mem_size_e size, word_t sdata, ppn_t ppn);
        int cyc;
        issue(ALU_ADD, va - 32'h40, 32'h40, ld, ~ld, size, sdata, 5'd3);
        wait_handoff(cyc);
        check("data_sram_req", 32'(data_sram_req), 1);
        check("data_sram_wr", 32'(data_sram_wr), ld ? 32'd0 : 32'd1);
        check("data_sram_size", 32'(data_sram_size), 32'(size));
        check("data_sram_wstrb", 32'(data_sram_wstrb), ld ? 32'd0 : 32'(model_strb(size, va[1:0])));
        if (!ld) check("data_sram_wdata", data_sram_wdata, model_wdata(size, sdata));
        check("data_sram_addr", data_sram_addr, {ppn, va[11:0]});
        check("ex_paddr", ex_paddr, {ppn, va[11:0]});
        check("ex_cause on access", 32'(ex_cause), 0);
        check("address result", ex_result, va);
    endtask

    task automatic run_exception(word_t va, mem_size_e size, ex_cause_t cause);
        int cyc;
        issue(ALU_ADD, va, '0, 1'b0, 1'b1, size, 32'h1234_5678, 5'd4);
        wait_handoff(cyc);
        check("exception latency", cyc, 1);
        check("ex_cause", 32'(ex_cause), 32'(cause));
        check("data_sram_req on exception", 32'(data_sram_req), 0);
        check("ex_paddr on exception", ex_paddr, 0);
    endtask

    task automatic test_backpressure();
        word_t va;
        int    hold;
        int    delay;
        int    cyc;
        va    = 32'h0002_0a48;    // entry 0 even page
        hold  = 2 + $unsigned($random(seed)) % 5;
        delay = 1 + $unsigned($random(seed)) % 5;
        @(negedge clk);
        mem_allowin       = 1'b0;
        data_sram_addr_ok = 1'b0;
        issue(ALU_ADD, va, '0, 1'b0, 1'b1, SIZE_WORD, 32'hcafe_f00d, 5'd9);
        for (int i = 0; i < hold; i++) begin
            #1;
            check("ex_allowin under back-pressure", 32'(ex_allowin), 0);
            check("data_sram_req under back-pressure", 32'(data_sram_req), 0);
            check("held ex_result", ex_result, va);
            check("held ex_rf_waddr", 32'(ex_rf_waddr), 9);
            @(negedge clk);
        end
        mem_allowin = 1'b1;
        for (int i = 0; i < delay; i++) begin
            #1;
            check("data_sram_req before addr_ok", 32'(data_sram_req), 1);
            check("ex_to_mem_valid before addr_ok", 32'(ex_to_mem_valid), 0);
            check("ex_allowin before addr_ok", 32'(ex_allowin), 0);
            @(negedge clk);
        end
        data_sram_addr_ok = 1'b1;
        wait_handoff(cyc);
        check("ex_result after back-pressure", ex_result, va);
        check("data_sram_addr after back-pressure", data_sram_addr, {20'h80001, va[11:0]});
        check("data_sram_wdata after back-pressure", data_sram_wdata, 32'hcafe_f00d);
        @(negedge clk);
        #1;
        check("repeated ex_to_mem_valid", 32'(ex_to_mem_valid), 0);
    endtask

    task automatic test_flush();
        int cyc;
        issue(ALU_DIVU, 32'hffff_0000, 32'd7, 1'b0, 1'b0, SIZE_WORD, '0, 5'd12);
        repeat (4) @(negedge clk);
        flush = 1'b1;    // mid division
        @(negedge clk);
        flush = 1'b0;
        for (int i = 0; i < 40; i++) begin
            #1;
            check("ex_to_mem_valid after flush", 32'(ex_to_mem_valid), 0);
            @(negedge clk);
        end
        issue(ALU_SUB, 32'd100, 32'd58, 1'b0, 1'b0, SIZE_WORD, '0, 5'd13);
        wait_handoff(cyc);
        check("latency after flush", cyc, 1);
        check("ex_result after flush", ex_result, 32'd42);
        check("ex_rf_waddr after flush", 32'(ex_rf_waddr), 13);
    endtask

    initial begin
        seed              = 59738;
        resetn            = 1'b0;
        flush             = 1'b0;
        csr_asid          = 10'd5;
        id_valid          = 1'b0;
        id_alu_op         = ALU_ADD;
        id_src1           = '0;
        id_src2           = '0;
        id_store_data     = '0;
        id_load           = 1'b0;
        id_store          = 1'b0;
        id_size           = SIZE_WORD;
        id_rf_we          = 1'b0;
        id_rf_waddr       = '0;
        mem_allowin       = 1'b1;
        data_sram_addr_ok = 1'b1;
        tlb_we            = 1'b0;
        tlb_w_index       = '0;
        tlb_w_vppn        = '0;
        tlb_w_asid        = '0;
        tlb_w_g           = 1'b0;
        tlb_w_ppn0        = '0;
        tlb_w_v0          = 1'b0;
        tlb_w_ppn1        = '0;
        tlb_w_v1          = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        fill_tlb(4'd0, 19'h00010, 10'd5, 1'b0, 20'h80001, 1'b1, 20'h80002, 1'b1);
        fill_tlb(4'd1, 19'h00020, 10'd9, 1'b1, 20'h90003, 1'b1, 20'h90004, 1'b0);    // global
        fill_tlb(4'd2, 19'h00030, 10'd7, 1'b0, 20'ha0005, 1'b1, 20'ha0006, 1'b1);

        test_single_cycle(40);
        test_division(12);

        run_access(1'b0, 32'h0002_0123, SIZE_BYTE, $random(seed), 20'h80001);
        run_access(1'b0, 32'h0002_1ab6, SIZE_HALF, $random(seed), 20'h80002);    // odd page
        run_access(1'b0, 32'h0002_1002, SIZE_HALF, $random(seed), 20'h80002);
        run_access(1'b0, 32'h0004_0ffc, SIZE_WORD, $random(seed), 20'h90003);    // asid 9 entry
        run_access(1'b1, 32'h0002_0010, SIZE_WORD, '0, 20'h80001);
        @(negedge clk);
        csr_asid = 10'd7;
        run_access(1'b0, 32'h0006_0a05, SIZE_BYTE, $random(seed), 20'ha0005);
        @(negedge clk);
        csr_asid = 10'd5;

        run_exception(32'h0002_0001, SIZE_HALF, 3'b001);    // ale
        run_exception(32'h0002_1006, SIZE_WORD, 3'b001);    // ale
        run_exception(32'h0040_0000, SIZE_WORD, 3'b010);    // unmapped
        run_exception(32'h0004_1000, SIZE_BYTE, 3'b100);    // v1 clear
        run_exception(32'h0006_0000, SIZE_WORD, 3'b010);    // wrong asid and not global

        test_backpressure();
        test_flush();

        if (uut.u_ex_stage.u_ex_checker.failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
common/ex_pkg.sv
common/alu_if.sv
common/tlb_search_if.sv
ex_stage/ex_alu.sv
ex_stage/ex_stage.sv
tlb/tlb.sv
rtl/ex_top.sv
verification/ex_checker.sv
verification/tb_ex_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_top -f vlog.f -o sim_ex_top

# the simulator exits nonzero on a fatal check, the search below decides
output=$(./obj_dir/sim_ex_top 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
